//--- logic/rx_dma_cmd.sv
/*
 * DDR write command generator with address tracking and req/ack
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module rx_dma_cmd (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_soft_rst,
    input  logic                    i_hdr_done,
    input  logic                    i_frame_end,
    input  logic [`RX_LEN_W-1:0]    i_length,
    input  logic                    i_rx_start,
    input  logic [`RX_ADDR_W-1:0]   i_base_addr,
    input  logic                    i_cmd_ack,
    output logic                    o_cmd_req,
    output rx_link_pkg::dma_cmd_t   o_cmd
);
    logic [`RX_ADDR_W-1:0]  addr_q;
    logic [`RX_LEN_W-1:0]   rnd_len;

    // DDR writes go in 8-byte units, e.g. 882 bytes become 888
    assign rnd_len = {i_length[`RX_LEN_W-1:3] + {{(`RX_LEN_W-4){1'b0}}, |i_length[2:0]},
                      3'b000};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            addr_q    <= `RX_RESET_ADDR;
            o_cmd_req <= 1'b0;
            o_cmd     <= '0;
        end else if (i_soft_rst) begin
            addr_q    <= `RX_RESET_ADDR;
            o_cmd_req <= 1'b0;
            o_cmd     <= '0;
        end else begin
            if (i_hdr_done) begin
                o_cmd_req      <= 1'b1;
                o_cmd.addr     <= addr_q;
                o_cmd.byte_cnt <= rnd_len;
            end else if (i_cmd_ack) begin
                o_cmd_req <= 1'b0;
            end

            // Start pulse wins over the per-frame advance
            if (i_rx_start) begin
                addr_q <= i_base_addr;
            end else if (i_frame_end) begin
                addr_q <= addr_q + {{(`RX_ADDR_W-`RX_LEN_W){1'b0}}, o_cmd.byte_cnt};
            end
        end
    end

endmodule

//--- logic/rx_frame_parser.sv
/*
 * Receive frame parser: sync and SOF detection, head flag match,
 * header capture, payload word output and checksum check
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module rx_frame_parser (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_soft_rst,
    input  rx_link_pkg::lane_word_t     i_lane,
    output logic                        o_pay_valid,
    output logic [`RX_WORD_W-1:0]       o_pay_data,
    output logic                        o_hdr_done,
    output logic                        o_frame_end,
    output rx_link_pkg::frame_info_t    o_info,
    output logic                        o_checksum_err,
    output rx_link_pkg::parser_state_e  o_state
);
    import rx_link_pkg::*;

    parser_state_e              state_q;
    parser_state_e              state_d;
    logic [`RX_WORD_W-1:0]      prev_data_q;
    logic [`RX_WORD_W-1:0]      csum_q;
    logic [`RX_LEN_W-2:0]       word_cnt_q;
    logic                       is_sync;
    logic                       is_sof;
    logic                       head_match;
    logic                       recv_last;

    assign is_sync    = (i_lane == `RX_SYNC_WORD);
    assign is_sof     = (i_lane == `RX_SOF_WORD);
    // Head flag spans two lane words, high half first
    assign head_match = ({prev_data_q, i_lane.data} == `RX_HEAD_FLAG);
    // Length is in bytes and always even, so length/2 words follow
    assign recv_last  = (word_cnt_q == o_info.byte_len[`RX_LEN_W-1:1] - 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (is_sync) begin
                    state_d = SYNC;
                end
            end
            SYNC: begin
                if (is_sof) begin
                    state_d = HEAD;
                end
            end
            HEAD: begin
                if (head_match) begin
                    state_d = TYPE;
                end
            end
            TYPE:    state_d = LINE;
            LINE:    state_d = LENGTH;
            LENGTH:  state_d = RECV;
            RECV: begin
                if (recv_last) begin
                    state_d = CHECK;
                end
            end
            CHECK:   state_d = END1;
            END1:    state_d = END2;
            END2:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q        <= IDLE;
            word_cnt_q     <= '0;
            o_checksum_err <= 1'b0;
        end else if (i_soft_rst) begin
            state_q        <= IDLE;
            word_cnt_q     <= '0;
            o_checksum_err <= 1'b0;
        end else begin
            state_q <= state_d;

            if (state_q == RECV) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end else begin
                word_cnt_q <= '0;
            end

            // Error flag lives until the next frame's type word
            if (state_q == TYPE) begin
                o_checksum_err <= 1'b0;
            end else if (state_q == CHECK) begin
                o_checksum_err <= (csum_q != i_lane.data);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Header fields and running checksum
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        prev_data_q <= i_lane.data;

        case (state_q)
            TYPE: begin
                csum_q <= i_lane.data;
                {o_info.file_end, o_info.chan_id, o_info.data_type,
                 o_info.line_num[`RX_LINE_W-1:16]} <= i_lane.data;
            end
            LINE: begin
                csum_q                <= csum_q + i_lane.data;
                o_info.line_num[15:0] <= i_lane.data;
            end
            LENGTH: begin
                csum_q          <= csum_q + i_lane.data;
                o_info.byte_len <= i_lane.data;
            end
            RECV:    csum_q <= csum_q + i_lane.data;
            default: csum_q <= csum_q;
        endcase
    end

    assign o_pay_valid = (state_q == RECV);
    assign o_pay_data  = i_lane.data;
    assign o_hdr_done  = (state_q == LENGTH);
    assign o_frame_end = (state_q == END1);
    assign o_state     = state_q;

endmodule

//--- logic/rx_link_defines.svh
/*
 * Widths, K-code words, frame head flag, reset address, FIFO depth
 * and link-loss holdoff for the TLK2711 receive link
 */
`ifndef RX_LINK_DEFINES_SVH
`define RX_LINK_DEFINES_SVH

`define RX_WORD_W               16
`define RX_ADDR_W               32
`define RX_LEN_W                16
`define RX_DMA_W                64
`define RX_LINE_W               24

// Lane words as {K msb, K lsb, data}
`define RX_SYNC_WORD            {1'b0, 1'b1, 16'hC5BC}
`define RX_SOF_WORD             {1'b1, 1'b1, 16'h5CFB}
`define RX_HEAD_FLAG            32'hEB90_E116
`define RX_LOSS_WORD            16'hFFFF

`define RX_RESET_ADDR           32'h5000_0000
`define RX_FIFO_DEPTH           512

// Roughly 100 ms at a 100 MHz link clock
`define RX_LOSS_HOLDOFF_CYCLES  10_000_000

`endif

//--- logic/rx_link_monitor.sv
/*
 * Link-loss detector with a holdoff timer after each report
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module rx_link_monitor #(
    parameter int unsigned LOSS_HOLDOFF = `RX_LOSS_HOLDOFF_CYCLES
) (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_soft_rst,
    input  logic                    i_loss_detect_ena,
    input  rx_link_pkg::lane_word_t i_lane,
    output logic                    o_link_loss
);
    localparam int CNT_W = $clog2(LOSS_HOLDOFF + 1);

    logic               is_loss;
    logic               hold_q;
    logic [CNT_W-1:0]   hold_cnt_q;

    // Both K flags with all-ones data means the serializer lost lock
    assign is_loss = i_lane.k_msb & i_lane.k_lsb & (i_lane.data == `RX_LOSS_WORD);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_link_loss <= 1'b0;
            hold_q      <= 1'b0;
            hold_cnt_q  <= '0;
        end else if (i_soft_rst || !i_loss_detect_ena) begin
            o_link_loss <= 1'b0;
            hold_q      <= 1'b0;
            hold_cnt_q  <= '0;
        end else begin
            // Pulse itself also blocks, since hold_q is not set yet
            o_link_loss <= is_loss & ~hold_q & ~o_link_loss;

            if (o_link_loss) begin
                hold_q     <= 1'b1;
                hold_cnt_q <= '0;
            end else if (hold_q) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
                if (hold_cnt_q == CNT_W'(LOSS_HOLDOFF - 1)) begin
                    hold_q <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/rx_link_pkg.sv
/*
 * Types of the receive link: lane word, frame info, DMA write command,
 * parser state and status word
 */
`include "rx_link_defines.svh"

package rx_link_pkg;

    typedef struct packed {
        logic                   k_msb;
        logic                   k_lsb;
        logic [`RX_WORD_W-1:0]  data;
    } lane_word_t;

    // Type word carries file end, channel, data type and line bits 23:16
    typedef struct packed {
        logic [1:0]             file_end;
        logic [1:0]             chan_id;
        logic [3:0]             data_type;
        logic [`RX_LINE_W-1:0]  line_num;
        logic [`RX_LEN_W-1:0]   byte_len;
    } frame_info_t;

    typedef struct packed {
        logic [`RX_ADDR_W-1:0]  addr;
        logic [`RX_LEN_W-1:0]   byte_cnt;
    } dma_cmd_t;

    typedef enum logic [3:0] {
        IDLE, SYNC, HEAD, TYPE, LINE, LENGTH, RECV, CHECK, END1, END2
    } parser_state_e;

    typedef struct packed {
        parser_state_e          state;
        logic                   fifo_empty;
        logic                   fifo_full;
    } rx_status_t;

endpackage

//--- logic/rx_pack_fifo.sv
/*
 * Packs 16-bit payload words into 64-bit DMA words, zero-pads the
 * last word of a frame and buffers the result in a circular FIFO
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module rx_pack_fifo (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_soft_rst,
    input  logic                    i_pay_valid,
    input  logic                    i_frame_end,
    input  logic [`RX_WORD_W-1:0]   i_pay_data,
    input  logic                    i_dma_ready,
    output logic                    o_dma_valid,
    output logic [`RX_DMA_W-1:0]    o_dma_data,
    output logic                    o_empty,
    output logic                    o_full
);
    localparam int WW    = `RX_WORD_W;
    localparam int DW    = `RX_DMA_W;
    localparam int LANES = DW / WW;
    localparam int LW    = $clog2(LANES);
    localparam int AW    = $clog2(`RX_FIFO_DEPTH);

    logic [LW-1:0]  lane_q;
    logic [DW-1:0]  asm_q;
    logic           wr_en_q;
    logic [DW-1:0]  wr_data_q;
    logic [AW:0]    wptr_q;
    logic [AW:0]    rptr_q;
    logic           push;
    logic           pop;
    logic [DW-1:0]  mem [`RX_FIFO_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Word assembly
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane_q  <= '0;
            wr_en_q <= 1'b0;
        end else if (i_soft_rst) begin
            lane_q  <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (i_pay_valid) begin
                lane_q <= lane_q + 1'b1;
                if (lane_q == LW'(LANES - 1)) begin
                    wr_en_q <= 1'b1;
                end
            end else if (i_frame_end && lane_q != '0) begin
                // Flush the partial word
                wr_en_q <= 1'b1;
                lane_q  <= '0;
            end
        end
    end

    // Lane 0 clears the upper lanes, so a partial word is already padded
    always_ff @(posedge clk) begin
        if (i_pay_valid) begin
            if (lane_q == '0) begin
                asm_q <= DW'(i_pay_data);
            end else begin
                asm_q[lane_q*WW +: WW] <= i_pay_data;
            end
            wr_data_q <= {i_pay_data, asm_q[DW-WW-1:0]};
        end else if (i_frame_end) begin
            wr_data_q <= asm_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FIFO
    ////////////////////////////////////////////////////////////////////////////

    assign push    = wr_en_q & ~o_full;
    assign pop     = o_dma_valid & i_dma_ready;
    assign o_empty = (wptr_q == rptr_q);
    assign o_full  = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else if (i_soft_rst) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr_q[AW-1:0]] <= wr_data_q;
        end
    end

    assign o_dma_valid = ~o_empty;
    assign o_dma_data  = mem[rptr_q[AW-1:0]];

endmodule

//--- logic/tlk2711_rx_link.sv
/*
 * TLK2711 receive link top: frame parser, payload packer with FIFO,
 * DMA command generator and link-loss monitor
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module tlk2711_rx_link #(
    parameter int unsigned LOSS_HOLDOFF = `RX_LOSS_HOLDOFF_CYCLES
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_soft_rst,
    input  rx_link_pkg::lane_word_t     i_lane,
    // DMA command
    input  logic                        i_rx_start,
    input  logic [`RX_ADDR_W-1:0]       i_base_addr,
    input  logic                        i_cmd_ack,
    output logic                        o_cmd_req,
    output rx_link_pkg::dma_cmd_t       o_cmd,
    // DMA data stream
    input  logic                        i_dma_ready,
    output logic                        o_dma_valid,
    output logic [`RX_DMA_W-1:0]        o_dma_data,
    // Frame results
    output rx_link_pkg::frame_info_t    o_frame_info,
    output logic                        o_frame_done,
    output logic                        o_checksum_err,
    // Link monitor and status
    input  logic                        i_loss_detect_ena,
    output logic                        o_link_loss,
    output rx_link_pkg::rx_status_t     o_status
);
    import rx_link_pkg::*;

    logic                   pay_valid;
    logic [`RX_WORD_W-1:0]  pay_data;
    logic                   hdr_done;
    logic                   frame_end;
    parser_state_e          parser_state;
    logic                   fifo_empty;
    logic                   fifo_full;

    rx_frame_parser u_parser (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_lane         (i_lane),
        .o_pay_valid    (pay_valid),
        .o_pay_data     (pay_data),
        .o_hdr_done     (hdr_done),
        .o_frame_end    (frame_end),
        .o_info         (o_frame_info),
        .o_checksum_err (o_checksum_err),
        .o_state        (parser_state)
    );

    rx_pack_fifo u_pack_fifo (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_pay_valid    (pay_valid),
        .i_frame_end    (frame_end),
        .i_pay_data     (pay_data),
        .i_dma_ready    (i_dma_ready),
        .o_dma_valid    (o_dma_valid),
        .o_dma_data     (o_dma_data),
        .o_empty        (fifo_empty),
        .o_full         (fifo_full)
    );

    // Length word is on the lane in the cycle that hdr_done is high
    rx_dma_cmd u_dma_cmd (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_hdr_done     (hdr_done),
        .i_frame_end    (frame_end),
        .i_length       (i_lane.data),
        .i_rx_start     (i_rx_start),
        .i_base_addr    (i_base_addr),
        .i_cmd_ack      (i_cmd_ack),
        .o_cmd_req      (o_cmd_req),
        .o_cmd          (o_cmd)
    );

    rx_link_monitor #(
        .LOSS_HOLDOFF   (LOSS_HOLDOFF)
    ) u_monitor (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_soft_rst         (i_soft_rst),
        .i_loss_detect_ena  (i_loss_detect_ena),
        .i_lane             (i_lane),
        .o_link_loss        (o_link_loss)
    );

    assign o_frame_done = frame_end;
    assign o_status     = '{state: parser_state, fifo_empty: fifo_empty, fifo_full: fifo_full};

endmodule

//--- run.sh
#!/bin/sh
# Build and run the receive link testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f verilog.f --top-module tb_rx_link -o tb_rx_link
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rx_link > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q -F "*** FAILED ***" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished, see $LOG"
exit 0

//--- testbench/rx_link_assert.sv
/*
 * Concurrent checks on the DMA command and data handshakes and on the
 * single-cycle frame-done and link-loss pulses, bound into the top level
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module rx_link_assert (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_soft_rst,
    input  logic                    i_cmd_req,
    input  logic                    i_cmd_ack,
    input  rx_link_pkg::dma_cmd_t   i_cmd,
    input  logic                    i_dma_valid,
    input  logic                    i_dma_ready,
    input  logic [`RX_DMA_W-1:0]    i_dma_data,
    input  logic                    i_frame_done,
    input  logic                    i_link_loss
);

    // Request holds with a stable command until it is acknowledged
    cmd_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cmd_req && !i_cmd_ack && !i_soft_rst |=> i_cmd_req && $stable(i_cmd))
        else $error("Command request dropped or changed before ack");

    // Stream word waits with stable data for ready
    dma_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dma_valid && !i_dma_ready && !i_soft_rst |=> i_dma_valid && $stable(i_dma_data))
        else $error("DMA valid dropped or data changed before ready");

    frame_done_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_frame_done |=> !i_frame_done)
        else $error("Frame done lasted more than one cycle");

    link_loss_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_link_loss |=> !i_link_loss)
        else $error("Link loss lasted more than one cycle");

endmodule

bind tlk2711_rx_link rx_link_assert u_rx_link_assert (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_soft_rst     (i_soft_rst),
    .i_cmd_req      (o_cmd_req),
    .i_cmd_ack      (i_cmd_ack),
    .i_cmd          (o_cmd),
    .i_dma_valid    (o_dma_valid),
    .i_dma_ready    (i_dma_ready),
    .i_dma_data     (o_dma_data),
    .i_frame_done   (o_frame_done),
    .i_link_loss    (o_link_loss)
);

//--- testbench/tb_rx_link.sv
/*
 * Testbench for the TLK2711 receive link with a frame sender, a DMA collector,
 * a reference model of packed words and commands, and directed tests
 */
`timescale 1ns/10ps
`include "rx_link_defines.svh"

module tb_rx_link;
    import rx_link_pkg::*;

    localparam int TIMEOUT = 5000;

    logic                   clk = 1'b0;
    logic                   i_arst_n;
    logic                   i_soft_rst;
    lane_word_t             i_lane;
    logic                   i_rx_start;
    logic [`RX_ADDR_W-1:0]  i_base_addr;
    logic                   i_cmd_ack;
    logic                   o_cmd_req;
    dma_cmd_t               o_cmd;
    logic                   i_dma_ready;
    logic                   o_dma_valid;
    logic [`RX_DMA_W-1:0]   o_dma_data;
    frame_info_t            o_frame_info;
    logic                   o_frame_done;
    logic                   o_checksum_err;
    logic                   i_loss_detect_ena;
    logic                   o_link_loss;
    rx_status_t             o_status;

    // Reference model state
    logic [31:0]            lfsr_q = 32'h7978;
    logic [`RX_ADDR_W-1:0]  exp_addr;
    frame_info_t            exp_info;
    int                     exp_frames;
    lane_word_t             tx_q[$];
    logic [`RX_DMA_W-1:0]   exp_words[$];
    dma_cmd_t               exp_cmds[$];
    string                  test_name;

    tlk2711_rx_link #(.LOSS_HOLDOFF(64)) UUT (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_failed();
        $display("*** FAILED ***");
        $fatal(1, "Test run stopped at first error");
    endtask

    task automatic show_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
        stop_failed();
    endtask

    task automatic complain(input string msg);
        $display("Error in %s: %s", test_name, msg);
        stop_failed();
    endtask

    // Galois LFSR, one step for each bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic void push_data(input logic [15:0] d);
        tx_q.push_back(lane_word_t'({2'b00, d}));
    endfunction

    // Queues one frame on the lane and its expected DMA words and command
    task automatic build_frame(input logic [15:0] len, input logic bad_csum);
        logic [31:0] head;
        logic [15:0] type_w;
        logic [15:0] line_w;
        logic [15:0] word;
        logic [15:0] sum;
        logic [15:0] rnd;
        logic [63:0] pack;
        int          lanes;
        head   = `RX_HEAD_FLAG;
        type_w = 16'(rand_bits(16));
        line_w = 16'(rand_bits(16));
        sum    = type_w + line_w + len;
        push_data(16'h0000);
        push_data(16'h0000);
        tx_q.push_back(lane_word_t'(`RX_SYNC_WORD));
        tx_q.push_back(lane_word_t'(`RX_SOF_WORD));
        push_data(head[31:16]);
        push_data(head[15:0]);
        push_data(type_w);
        push_data(line_w);
        push_data(len);
        pack  = '0;
        lanes = 0;
        for (int i = 0; i < int'(len) / 2; i++) begin
            word = 16'(rand_bits(16));
            sum  = sum + word;
            push_data(word);
            pack[lanes*16 +: 16] = word;
            lanes++;
            if (lanes == 4) begin
                exp_words.push_back(pack);
                pack  = '0;
                lanes = 0;
            end
        end
        if (lanes != 0) begin
            exp_words.push_back(pack);
        end
        push_data(bad_csum ? ~sum : sum);
        push_data(16'hFEFE);
        push_data(16'hFEFE);
        rnd = 16'(((int'(len) + 7) / 8) * 8);
        exp_cmds.push_back(dma_cmd_t'({exp_addr, rnd}));
        exp_addr = exp_addr + 32'(rnd);
        exp_info = frame_info_t'({type_w, line_w, len});
        exp_frames++;
    endtask

    task automatic send_lane();
        while (tx_q.size() > 0) begin
            @(posedge clk);
            i_lane <= tx_q.pop_front();
        end
        @(posedge clk);
        i_lane <= '0;
    endtask

    // Acks commands and takes DMA words with random ready stalls
    task automatic collect();
        int   cycles;
        int   done_cnt;
        logic ack_next;
        cycles   = 0;
        done_cnt = 0;
        ack_next = 1'b0;
        while ((exp_words.size() > 0 || exp_cmds.size() > 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            i_dma_ready <= (rand_bits(2) != 0);
            i_cmd_ack   <= ack_next;
            @(negedge clk);
            cycles++;
            if (o_frame_done) begin
                done_cnt++;
            end
            ack_next = o_cmd_req && !i_cmd_ack;
            if (ack_next) begin
                assert (exp_cmds.size() > 0) else complain("unexpected DMA command");
                assert (o_cmd == exp_cmds[0])
                    else show_mismatch("DMA command", exp_cmds[0], o_cmd);
                void'(exp_cmds.pop_front());
            end
            if (o_dma_valid && i_dma_ready) begin
                assert (exp_words.size() > 0) else complain("unexpected DMA word");
                assert (o_dma_data == exp_words[0])
                    else show_mismatch("DMA word", exp_words[0], o_dma_data);
                void'(exp_words.pop_front());
            end
        end
        assert (exp_words.size() == 0 && exp_cmds.size() == 0)
            else complain("timeout waiting for DMA words and commands");
        assert (done_cnt == exp_frames)
            else show_mismatch("frame done pulses", exp_frames, done_cnt);
        exp_frames = 0;
        @(posedge clk);
        i_dma_ready <= 1'b0;
        i_cmd_ack   <= ack_next;
        @(posedge clk);
        i_cmd_ack   <= 1'b0;
    endtask

    task automatic run_frames();
        fork
            send_lane();
            collect();
        join
        @(negedge clk);
        assert (!o_dma_valid) else complain("FIFO holds words beyond the expected ones");
        assert (o_status.fifo_empty) else complain("status does not show the FIFO empty");
        assert (!o_status.fifo_full) else complain("status shows the FIFO full");
        assert (!o_cmd_req) else complain("command request still high after ack");
    endtask

    task automatic send_loss(output int pulses);
        @(posedge clk);
        i_lane <= lane_word_t'({1'b1, 1'b1, `RX_LOSS_WORD});
        @(posedge clk);
        i_lane <= '0;
        pulses = 0;
        repeat (4) begin
            @(negedge clk);
            if (o_link_loss) begin
                pulses++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_single_frame();
        test_name = "single_frame";
        build_frame(16'd882, 1'b0);
        run_frames();
        assert (o_frame_info == exp_info)
            else show_mismatch("frame info", exp_info, o_frame_info);
        assert (!o_checksum_err) else complain("checksum error flagged on a good frame");
    endtask

    task automatic test_bad_checksum();
        test_name = "bad_checksum";
        build_frame(16'd20, 1'b1);
        run_frames();
        assert (o_checksum_err) else complain("wrong checksum was not flagged");
        build_frame(16'd12, 1'b0);
        run_frames();
        assert (!o_checksum_err) else complain("checksum error not cleared by a good frame");
    endtask

    task automatic test_back_to_back();
        test_name = "back_to_back";
        @(posedge clk);
        i_rx_start  <= 1'b1;
        i_base_addr <= 32'h8000_1000;
        @(posedge clk);
        i_rx_start  <= 1'b0;
        exp_addr = 32'h8000_1000;
        build_frame(16'd10, 1'b0);
        build_frame(16'd16, 1'b0);
        build_frame(16'd42, 1'b0);
        run_frames();
        assert (o_frame_info == exp_info)
            else show_mismatch("frame info", exp_info, o_frame_info);
    endtask

    task automatic test_soft_reset();
        test_name = "soft_reset";
        build_frame(16'd40, 1'b0);
        // Stop after the header and three payload words
        while (tx_q.size() > 12) begin
            void'(tx_q.pop_back());
        end
        send_lane();
        @(negedge clk);
        assert (o_status.state == RECV)
            else show_mismatch("state before reset", 64'(RECV), 64'(o_status.state));
        @(posedge clk);
        i_soft_rst <= 1'b1;
        @(posedge clk);
        i_soft_rst <= 1'b0;
        @(negedge clk);
        assert (o_status.state == IDLE)
            else show_mismatch("state after reset", 64'(IDLE), 64'(o_status.state));
        assert (!o_dma_valid) else complain("DMA valid high after soft reset");
        assert (!o_cmd_req) else complain("command request high after soft reset");
        exp_words.delete();
        exp_cmds.delete();
        exp_frames = 0;
        exp_addr   = `RX_RESET_ADDR;
        build_frame(16'd24, 1'b0);
        run_frames();
        assert (o_frame_info == exp_info)
            else show_mismatch("frame info", exp_info, o_frame_info);
    endtask

    task automatic test_link_loss();
        int pulses;
        test_name = "link_loss";
        @(posedge clk);
        i_loss_detect_ena <= 1'b1;
        send_loss(pulses);
        assert (pulses == 1) else show_mismatch("first loss pulses", 1, pulses);
        repeat (10) @(posedge clk);
        send_loss(pulses);
        assert (pulses == 0) else show_mismatch("pulses in holdoff", 0, pulses);
        repeat (70) @(posedge clk);
        send_loss(pulses);
        assert (pulses == 1) else show_mismatch("pulses after holdoff", 1, pulses);
        @(posedge clk);
        i_loss_detect_ena <= 1'b0;
        repeat (70) @(posedge clk);
        send_loss(pulses);
        assert (pulses == 0) else show_mismatch("pulses when disabled", 0, pulses);
    endtask

    initial begin
        i_arst_n          = 1'b0;
        i_soft_rst        = 1'b0;
        i_lane            = '0;
        i_rx_start        = 1'b0;
        i_base_addr       = '0;
        i_cmd_ack         = 1'b0;
        i_dma_ready       = 1'b0;
        i_loss_detect_ena = 1'b0;
        exp_addr          = `RX_RESET_ADDR;
        exp_frames        = 0;
        test_name         = "reset";
        repeat (8) @(posedge clk);
        i_arst_n <= 1'b1;
        @(posedge clk);
        test_single_frame();
        test_bad_checksum();
        test_back_to_back();
        test_soft_reset();
        test_link_loss();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/rx_link_pkg.sv
logic/rx_frame_parser.sv
logic/rx_pack_fifo.sv
logic/rx_dma_cmd.sv
logic/rx_link_monitor.sv
logic/tlk2711_rx_link.sv
testbench/rx_link_assert.sv
testbench/tb_rx_link.sv
